// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int ADDR_BITS  = 32;
    localparam int BYTE_BITS  = 8;
    localparam int WORD_BYTES = 4;
    localparam int DATA_BYTES = 8;
    localparam int WORD_BITS  = BYTE_BITS * WORD_BYTES;
    localparam int DATA_BITS  = BYTE_BITS * DATA_BYTES;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [DATA_BITS-1:0]  data_t;
    typedef logic [DATA_BYTES-1:0] strobe_t;

    // cache bus request size and burst length codes
    typedef logic [2:0] size_t;
    typedef logic [3:0] len_t;

    // 4 bytes per beat
    localparam size_t MSIZE4 = 3'b010;
    // 16 beats, encoded as beats minus one
    localparam len_t  MLEN16 = 4'b1111;

endpackage

`default_nettype wire

// File: src/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    localparam int WAYS           = 2;
    localparam int SETS           = 256;
    localparam int DATA_PER_LINE  = 8;
    localparam int WORDS_PER_LINE = 16;

    localparam int WAY_BITS       = $clog2(WAYS);
    localparam int INDEX_BITS     = $clog2(SETS);
    localparam int OFFSET_BITS    = $clog2(DATA_PER_LINE);
    localparam int ALIGN_BITS     = $clog2(bus_pkg::DATA_BYTES);
    localparam int WORD_NUM_BITS  = $clog2(WORDS_PER_LINE);
    localparam int TAG_BITS       = bus_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int DATA_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [WAY_BITS-1:0]      way_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;
    typedef logic [ALIGN_BITS-1:0]    align_t;
    typedef logic [WORD_NUM_BITS-1:0] word_num_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        align_t  align;
    } addr_fields_t;

    // fetch path decodes the fields, bus path uses the flat word
    typedef union packed {
        bus_pkg::addr_t flat;
        addr_fields_t   f;
    } addr_u;

    // one 64-bit entry of the data RAM
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

endpackage

`default_nettype wire

// File: src/refill_if.sv
`timescale 1ns/1ps
`default_nettype none

interface refill_if;

    // data RAM write port
    logic                       wr_en;
    cache_geom_pkg::data_addr_t wr_addr;
    bus_pkg::strobe_t           wr_strobe;
    bus_pkg::data_t             wr_data;

    // refill progress
    logic                                       busy;
    cache_geom_pkg::tag_t                       line_tag;
    cache_geom_pkg::index_t                     line_index;
    logic [cache_geom_pkg::WORDS_PER_LINE-1:0]  arrived;

    modport producer (
        output wr_en, wr_addr, wr_strobe, wr_data,
        output busy, line_tag, line_index, arrived
    );

    modport buffer (
        input wr_en, wr_addr, wr_strobe, wr_data
    );

    modport monitor (
        input busy, line_tag, line_index, arrived
    );

endinterface

`default_nettype wire

// File: src/tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tag_lookup (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  ireq_valid,
    input  cache_geom_pkg::addr_u ireq_addr,
    refill_if.monitor             rf,
    output logic                  hit,
    output cache_geom_pkg::way_t  hit_way,
    output logic                  miss_start,
    output cache_geom_pkg::way_t  victim_way
);

    cache_geom_pkg::tag_t tag_ram [cache_geom_pkg::WAYS][cache_geom_pkg::SETS];
    logic [cache_geom_pkg::SETS-1:0] valid_q [cache_geom_pkg::WAYS];

    // one bit per set, points at the next victim
    logic [cache_geom_pkg::SETS-1:0] plru_q;

    cache_geom_pkg::tag_t      req_tag;
    cache_geom_pkg::index_t    req_index;
    cache_geom_pkg::word_num_t lo_word;
    cache_geom_pkg::word_num_t hi_word;
    logic [cache_geom_pkg::WAYS-1:0] way_match;
    logic tag_match;
    logic on_refill_line;
    logic entry_arrived;

    assign req_tag   = ireq_addr.f.tag;
    assign req_index = ireq_addr.f.index;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            way_match[w] = valid_q[w][req_index] && (tag_ram[w][req_index] == req_tag);
            if (way_match[w]) begin
                hit_way = cache_geom_pkg::way_t'(w);
            end
        end
        tag_match = |way_match;
    end

    // both words of the 64-bit entry must be in the RAM
    assign lo_word       = {ireq_addr.f.offset, 1'b0};
    assign hi_word       = {ireq_addr.f.offset, 1'b1};
    assign entry_arrived = rf.arrived[lo_word] & rf.arrived[hi_word];

    assign on_refill_line = rf.busy
                          && (req_tag == rf.line_tag)
                          && (req_index == rf.line_index);

    assign hit        = ireq_valid && tag_match && (!on_refill_line || entry_arrived);
    assign miss_start = ireq_valid && !tag_match && !rf.busy;
    assign victim_way = plru_q[req_index];

    // claim the victim way as soon as the miss is taken
    always_ff @(posedge clk) begin
        if (miss_start) begin
            tag_ram[victim_way][req_index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (miss_start) begin
            valid_q[victim_way][req_index] <= 1'b1;
        end
    end

    // only hits move the LRU bit
    always_ff @(posedge clk) begin
        if (resetn) begin
            plru_q <= '0;
        end else if (hit) begin
            plru_q[req_index] <= ~hit_way;
        end
    end

endmodule

`default_nettype wire

// File: src/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  miss_start,
    input  cache_geom_pkg::way_t  victim_way,
    input  cache_geom_pkg::addr_u miss_addr,
    refill_if.producer            rf,
    output logic                  icreq_valid,
    output bus_pkg::addr_t        icreq_addr,
    input  logic                  icresp_ready,
    input  logic                  icresp_last,
    input  bus_pkg::word_t        icresp_data
);

    typedef enum logic {
        IDLE,
        FETCH
    } state_t;

    state_t                     state_q;
    cache_geom_pkg::addr_u      line_addr_q;
    cache_geom_pkg::data_addr_t wr_ptr_q;
    cache_geom_pkg::word_num_t  word_cnt_q;
    logic [cache_geom_pkg::WORDS_PER_LINE-1:0] arrived_q;
    logic beat;

    assign beat = (state_q == FETCH) && icresp_ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q   <= IDLE;
            arrived_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (miss_start) begin
                        state_q   <= FETCH;
                        arrived_q <= '0;
                    end
                end
                FETCH: begin
                    if (icresp_ready) begin
                        arrived_q[word_cnt_q] <= 1'b1;
                        if (icresp_last) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // burst starts at the requested word and wraps in the line
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && miss_start) begin
            line_addr_q     <= miss_addr;
            wr_ptr_q.way    <= victim_way;
            wr_ptr_q.index  <= miss_addr.f.index;
            wr_ptr_q.offset <= miss_addr.f.offset;
            word_cnt_q      <= {miss_addr.f.offset,
                                miss_addr.f.align[cache_geom_pkg::ALIGN_BITS-1]};
        end else if (beat) begin
            word_cnt_q <= word_cnt_q + 1'b1;
            // next entry once the high half is in
            if (word_cnt_q[0]) begin
                wr_ptr_q.offset <= wr_ptr_q.offset + 1'b1;
            end
        end
    end

    assign icreq_valid = (state_q == FETCH);
    assign icreq_addr  = line_addr_q.flat;

    assign rf.wr_en     = beat;
    assign rf.wr_addr   = wr_ptr_q;
    assign rf.wr_strobe = word_cnt_q[0]
                        ? {{bus_pkg::WORD_BYTES{1'b1}}, {bus_pkg::WORD_BYTES{1'b0}}}
                        : {{bus_pkg::WORD_BYTES{1'b0}}, {bus_pkg::WORD_BYTES{1'b1}}};
    assign rf.wr_data   = {icresp_data, icresp_data};

    assign rf.busy       = (state_q == FETCH);
    assign rf.line_tag   = line_addr_q.f.tag;
    assign rf.line_index = line_addr_q.f.index;
    assign rf.arrived    = arrived_q;

endmodule

`default_nettype wire

// File: src/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  logic                       clk,
    input  cache_geom_pkg::data_addr_t rd_addr,
    output bus_pkg::data_t             rd_data,
    refill_if.buffer                   rf
);

    // way, set and entry flattened into one address
    bus_pkg::data_t mem [2**cache_geom_pkg::DATA_ADDR_BITS];

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // refill writes one 32-bit half per beat
    always_ff @(posedge clk) begin
        if (rf.wr_en) begin
            for (int b = 0; b < bus_pkg::DATA_BYTES; b++) begin
                if (rf.wr_strobe[b]) begin
                    mem[rf.wr_addr][b*bus_pkg::BYTE_BITS +: bus_pkg::BYTE_BITS]
                        <= rf.wr_data[b*bus_pkg::BYTE_BITS +: bus_pkg::BYTE_BITS];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic             clk,
    input  logic             resetn,

    // fetch side
    input  logic             ireq_valid,
    input  bus_pkg::addr_t   ireq_addr,
    output logic             iresp_addr_ok,
    output logic             iresp_data_ok,
    output bus_pkg::data_t   iresp_data,

    // cache bus side
    output logic             icreq_valid,
    output bus_pkg::addr_t   icreq_addr,
    output bus_pkg::size_t   icreq_size,
    output bus_pkg::len_t    icreq_len,
    input  logic             icresp_ready,
    input  logic             icresp_last,
    input  bus_pkg::word_t   icresp_data
);

    cache_geom_pkg::addr_u      req_addr;
    cache_geom_pkg::data_addr_t rd_addr;
    cache_geom_pkg::way_t       hit_way;
    cache_geom_pkg::way_t       victim_way;
    logic hit;
    logic miss_start;

    refill_if rf ();

    assign req_addr.flat = ireq_addr;

    tag_lookup u_tag_lookup (
        .clk        (clk),
        .resetn     (resetn),
        .ireq_valid (ireq_valid),
        .ireq_addr  (req_addr),
        .rf         (rf),
        .hit        (hit),
        .hit_way    (hit_way),
        .miss_start (miss_start),
        .victim_way (victim_way)
    );

    line_refill u_line_refill (
        .clk          (clk),
        .resetn       (resetn),
        .miss_start   (miss_start),
        .victim_way   (victim_way),
        .miss_addr    (req_addr),
        .rf           (rf),
        .icreq_valid  (icreq_valid),
        .icreq_addr   (icreq_addr),
        .icresp_ready (icresp_ready),
        .icresp_last  (icresp_last),
        .icresp_data  (icresp_data)
    );

    // read the hitting way, data comes back next cycle
    always_comb begin
        rd_addr.way    = hit_way;
        rd_addr.index  = req_addr.f.index;
        rd_addr.offset = req_addr.f.offset;
    end

    data_store u_data_store (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (iresp_data),
        .rf      (rf)
    );

    assign iresp_addr_ok = hit;

    always_ff @(posedge clk) begin
        if (resetn) begin
            iresp_data_ok <= 1'b0;
        end else begin
            iresp_data_ok <= hit;
        end
    end

    // every refill is a full 16-word line of 32-bit beats
    assign icreq_size = bus_pkg::MSIZE4;
    assign icreq_len  = bus_pkg::MLEN16;

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic resetn
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over five rising edges
    initial begin
        resetn = 1'b1;
        repeat (5) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/cbus_mem.sv
`timescale 1ns/1ps
`default_nettype none

module cbus_mem (
    input  logic           clk,
    input  logic           resetn,
    input  logic           icreq_valid,
    input  bus_pkg::addr_t icreq_addr,
    output logic           icresp_ready,
    output logic           icresp_last,
    output bus_pkg::word_t icresp_data
);

    // every word is the inverse of its byte address, burst wraps in the 64-byte line
    function automatic bus_pkg::word_t mem_word(input bus_pkg::addr_t start, input int beat);
        logic [3:0]     w;
        bus_pkg::addr_t a;
        w = start[5:2] + 4'(beat);
        a = {start[31:6], w, 2'b00};
        return ~a;
    endfunction

    initial begin
        int             sent;
        logic           active;
        bus_pkg::addr_t start;
        void'($urandom(20439));
        icresp_ready = 1'b0;
        icresp_last  = 1'b0;
        icresp_data  = '0;
        active       = 1'b0;
        sent         = 0;
        start        = '0;
        forever begin
            @(posedge clk);
            if (resetn) begin
                active = 1'b0;
                sent   = 0;
            end else if (active && icresp_ready) begin
                // the beat offered last cycle was taken at this edge
                sent = sent + 1;
                if (icresp_last) begin
                    active = 1'b0;
                end
            end else if (!active && icreq_valid) begin
                active = 1'b1;
                start  = icreq_addr;
                sent   = 0;
            end
            // roughly one cycle in four is a ready gap
            if (!resetn && active && (($urandom % 4) != 0)) begin
                icresp_ready <= 1'b1;
                icresp_last  <= (sent == 15);
                icresp_data  <= mem_word(start, sent);
            end else begin
                icresp_ready <= 1'b0;
                icresp_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int NSTEPS      = 18;
    localparam int STEP_LIMIT  = 200;
    localparam int RESET_LIMIT = 20;

    // beat size code is log2 of the 4 bytes in a word
    localparam bus_pkg::size_t SIZE_CODE = 3'($clog2(4));
    // burst length code is the 16 words of a line minus one
    localparam bus_pkg::len_t  LEN_CODE  = 4'(16 - 1);

    typedef struct packed {
        bus_pkg::addr_t addr;
        logic           hit;
        logic           early;
        logic           fast;
    } step_t;

    // early means addr_ok while a refill still runs
    // fast means addr_ok in the first cycle
    step_t steps [NSTEPS] = '{
        '{32'h0000_4490, 1'b0, 1'b1, 1'b0},
        '{32'h0000_4490, 1'b1, 1'b1, 1'b0},
        '{32'h0000_4494, 1'b1, 1'b1, 1'b0},
        '{32'h0000_4480, 1'b1, 1'b0, 1'b0},
        '{32'h0000_4488, 1'b1, 1'b0, 1'b0},
        '{32'h0000_4498, 1'b1, 1'b0, 1'b1},
        '{32'h0000_44a0, 1'b1, 1'b0, 1'b1},
        '{32'h0000_44a8, 1'b1, 1'b0, 1'b1},
        '{32'h0000_44b0, 1'b1, 1'b0, 1'b1},
        '{32'h0000_44b8, 1'b1, 1'b0, 1'b1},
        '{32'h0000_4490, 1'b1, 1'b0, 1'b1},
        '{32'h0000_4498, 1'b1, 1'b0, 1'b1},
        '{32'h0000_8d48, 1'b0, 1'b0, 1'b0},
        '{32'h0000_cd4c, 1'b0, 1'b0, 1'b0},
        '{32'h0000_8d40, 1'b1, 1'b0, 1'b1},
        '{32'h0001_0d50, 1'b0, 1'b0, 1'b0},
        '{32'h0000_8d58, 1'b1, 1'b0, 1'b1},
        '{32'h0000_cd48, 1'b0, 1'b0, 1'b0}
    };

    logic           clk;
    logic           resetn;
    logic           ireq_valid;
    bus_pkg::addr_t ireq_addr;
    logic           iresp_addr_ok;
    logic           iresp_data_ok;
    bus_pkg::data_t iresp_data;
    logic           icreq_valid;
    bus_pkg::addr_t icreq_addr;
    bus_pkg::size_t icreq_size;
    bus_pkg::len_t  icreq_len;
    logic           icresp_ready;
    logic           icresp_last;
    bus_pkg::word_t icresp_data;

    int errors;
    int done_steps;
    int passed_steps;
    int step_errs [NSTEPS];

    clk_gen u_clk_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    cbus_mem u_cbus_mem (
        .clk          (clk),
        .resetn       (resetn),
        .icreq_valid  (icreq_valid),
        .icreq_addr   (icreq_addr),
        .icresp_ready (icresp_ready),
        .icresp_last  (icresp_last),
        .icresp_data  (icresp_data)
    );

    icache_top dut0 (
        .clk           (clk),
        .resetn        (resetn),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .icreq_valid   (icreq_valid),
        .icreq_addr    (icreq_addr),
        .icreq_size    (icreq_size),
        .icreq_len     (icreq_len),
        .icresp_ready  (icresp_ready),
        .icresp_last   (icresp_last),
        .icresp_data   (icresp_data)
    );

    // low half from the even word, high half from the odd word
    function automatic bus_pkg::data_t expected_entry(input bus_pkg::addr_t addr);
        bus_pkg::addr_t base;
        base = {addr[31:3], 3'b000};
        return {~(base + 32'd4), ~base};
    endfunction

    task automatic check_data(input int step, input string name,
                              input bus_pkg::data_t exp, input bus_pkg::data_t got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h got %h (step %0d)", $time, name, exp, got, step);
            errors++;
            step_errs[step]++;
        end
    endtask

    task automatic check_addr(input int step, input string name,
                              input bus_pkg::addr_t exp, input bus_pkg::addr_t got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %h got %h (step %0d)", $time, name, exp, got, step);
            errors++;
            step_errs[step]++;
        end
    endtask

    task automatic check_size(input int step, input string name,
                              input bus_pkg::size_t exp, input bus_pkg::size_t got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b (step %0d)", $time, name, exp, got, step);
            errors++;
            step_errs[step]++;
        end
    endtask

    task automatic check_len(input int step, input string name,
                             input bus_pkg::len_t exp, input bus_pkg::len_t got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b (step %0d)", $time, name, exp, got, step);
            errors++;
            step_errs[step]++;
        end
    endtask

    task automatic check_flag(input int step, input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %b got %b (step %0d)", $time, name, exp, got, step);
            errors++;
            step_errs[step]++;
        end
    endtask

    task automatic report_step(input int step);
        done_steps++;
        if (step_errs[step] == 0) begin
            passed_steps++;
        end
        $display("step %0d addr %h %s: %s", step, steps[step].addr,
                 steps[step].hit ? "hit" : "miss", (step_errs[step] == 0) ? "ok" : "bad");
    endtask

    initial begin
        int             step;
        int             waited;
        int             rises;
        int             pend_step;
        logic           pending;
        logic           prev_icreq;
        logic           refill_active;
        logic           last_now;
        logic           timed_out;
        bus_pkg::data_t pend_data;
        ireq_valid    = 1'b0;
        ireq_addr     = '0;
        errors        = 0;
        done_steps    = 0;
        passed_steps  = 0;
        step          = 0;
        waited        = 0;
        rises         = 0;
        pend_step     = 0;
        pending       = 1'b0;
        prev_icreq    = 1'b0;
        refill_active = 1'b0;
        timed_out     = 1'b0;
        pend_data     = '0;
        foreach (step_errs[i]) step_errs[i] = 0;

        for (int i = 0; i < RESET_LIMIT && resetn !== 1'b0; i++) begin
            @(negedge clk);
        end
        if (resetn !== 1'b0) begin
            $display("reset was never released");
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            @(posedge clk);
            ireq_valid <= 1'b1;
            ireq_addr  <= steps[0].addr;
        end
        while (!timed_out && (step < NSTEPS || pending)) begin
            @(negedge clk);
            last_now = icreq_valid && icresp_ready && icresp_last;
            // data for the request accepted one cycle ago
            if (pending) begin
                if (iresp_data_ok === 1'b1) begin
                    check_data(pend_step, "iresp_data", pend_data, iresp_data);
                end else begin
                    $display("step %0d: data_ok did not follow addr_ok at %0t", pend_step, $time);
                    errors++;
                    step_errs[pend_step]++;
                end
                report_step(pend_step);
                pending = 1'b0;
            end else if (iresp_data_ok !== 1'b0) begin
                $display("data_ok pulsed with no request accepted at %0t", $time);
                errors++;
            end
            if (icreq_valid && !prev_icreq) begin
                refill_active = 1'b1;
                if (step < NSTEPS) begin
                    rises++;
                    check_addr(step, "icreq_addr", steps[step].addr, icreq_addr);
                    check_size(step, "icreq_size", SIZE_CODE, icreq_size);
                    check_len(step, "icreq_len", LEN_CODE, icreq_len);
                end
            end
            if (step < NSTEPS) begin
                if (iresp_addr_ok === 1'b1) begin
                    check_flag(step, "hit", steps[step].hit, rises == 0);
                    if (rises > 1) begin
                        $display("step %0d started %0d refills instead of one", step, rises);
                        errors++;
                        step_errs[step]++;
                    end
                    if (steps[step].early) begin
                        check_flag(step, "early addr_ok", 1'b1, refill_active && !last_now);
                    end
                    if (steps[step].fast) begin
                        check_flag(step, "first cycle addr_ok", 1'b1, waited == 0);
                    end
                    pending   = 1'b1;
                    pend_step = step;
                    pend_data = expected_entry(steps[step].addr);
                    step++;
                    waited    = 0;
                    rises     = 0;
                end else begin
                    waited++;
                    if (waited > STEP_LIMIT) begin
                        $display("step %0d got no addr_ok within %0d cycles", step, STEP_LIMIT);
                        timed_out = 1'b1;
                    end
                end
            end
            if (last_now) begin
                refill_active = 1'b0;
            end
            prev_icreq = icreq_valid;
            @(posedge clk);
            if (step < NSTEPS) begin
                ireq_valid <= 1'b1;
                ireq_addr  <= steps[step].addr;
            end else begin
                ireq_valid <= 1'b0;
            end
        end

        $display("%0d of %0d steps done, %0d passed, %0d failed, %0d errors",
                 done_steps, NSTEPS, passed_steps, done_steps - passed_steps, errors);
        if (errors == 0 && !timed_out && done_steps == NSTEPS) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/bus_pkg.sv
src/cache_geom_pkg.sv
src/refill_if.sv
src/tag_lookup.sv
src/line_refill.sv
src/data_store.sv
src/icache_top.sv
dv/clk_gen.sv
dv/cbus_mem.sv
dv/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module icache_tb -f tb.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -x "TESTS PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
